// ==== rtl/axi_node_cfg_pkg.sv ====
`default_nettype none

package axi_node_cfg_pkg;

  // AXI4-Lite bus geometry
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // each region of each master port owns a block of four consecutive words
  localparam int unsigned WORDS_PER_REGION = 4;

  // word slots inside one region block
  localparam int unsigned RULE_START_SLOT = 0;
  localparam int unsigned RULE_END_SLOT   = 1;
  localparam int unsigned RULE_VALID_SLOT = 2;
  // the fourth slot holds no state and always reads back the marker below
  localparam int unsigned RULE_RSVD_SLOT  = 3;

  // connectivity words start at byte offset 0x1000, one word per slave port
  localparam int unsigned CONN_BASE_WORD = 32'h0000_0400;

  // value seen when reading a reserved slot
  localparam logic [DATA_WIDTH-1:0] RSVD_MARKER = 32'hDEAD_BEEF;

  // the block never signals an error, every response is OKAY
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // byte address with the two byte-lane bits dropped
  typedef logic [ADDR_WIDTH-3:0] word_addr_t;

  // one configuration register
  typedef logic [DATA_WIDTH-1:0] cfg_word_t;

  // a complete write, handed from the AXI write side to the register file
  // in a single cycle once address and data have both arrived
  typedef struct packed {
    word_addr_t            addr;
    cfg_word_t             data;
    logic [STRB_WIDTH-1:0] strb;
  } cfg_wr_req_t;

endpackage

`default_nettype wire

// ==== rtl/cfg_axi_write_slave.sv ====
`default_nettype none

module cfg_axi_write_slave (
  input  wire                                          s_axi_aclk,
  input  wire                                          s_axi_aresetn,
  input  wire  [axi_node_cfg_pkg::ADDR_WIDTH-1:0]      s_axi_awaddr_i,
  input  wire                                          s_axi_awvalid_i,
  output logic                                         s_axi_awready_o,
  input  wire  axi_node_cfg_pkg::cfg_word_t            s_axi_wdata_i,
  input  wire  [axi_node_cfg_pkg::STRB_WIDTH-1:0]      s_axi_wstrb_i,
  input  wire                                          s_axi_wvalid_i,
  output logic                                         s_axi_wready_o,
  input  wire                                          s_axi_bready_i,
  output logic                                         s_axi_bvalid_o,
  output logic [1:0]                                   s_axi_bresp_o,
  output axi_node_cfg_pkg::cfg_wr_req_t                wr_req_o,
  output logic                                         wr_en_o
);

  import axi_node_cfg_pkg::*;

  // the two channels are accepted on their own, in either order
  logic                  awready_q;
  logic                  wready_q;
  logic                  aw_held_q;
  logic                  w_held_q;
  logic                  bvalid_q;
  // marks the cycle right after the response handshake
  logic                  b_done_q;
  logic                  wr_en_q;
  logic                  issue;
  word_addr_t            awaddr_q;
  cfg_word_t             wdata_q;
  logic [STRB_WIDTH-1:0] wstrb_q;

  // both halves are in and no response has been raised for them yet
  assign issue = aw_held_q && w_held_q && !bvalid_q && !b_done_q;

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
    begin
      awready_q <= 1'b1;
      wready_q  <= 1'b1;
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      b_done_q  <= 1'b0;
      wr_en_q   <= 1'b0;
    end
    else
    begin
      // the update pulse and bvalid start on the same edge
      wr_en_q <= issue;
      if (b_done_q)
      begin
        // response taken on the previous edge, reopen both channels
        awready_q <= 1'b1;
        wready_q  <= 1'b1;
        aw_held_q <= 1'b0;
        w_held_q  <= 1'b0;
        b_done_q  <= 1'b0;
      end
      else
      begin
        if (awready_q && s_axi_awvalid_i)
        begin
          awready_q <= 1'b0;
          aw_held_q <= 1'b1;
        end
        if (wready_q && s_axi_wvalid_i)
        begin
          wready_q <= 1'b0;
          w_held_q <= 1'b1;
        end
        if (issue)
        begin
          bvalid_q <= 1'b1;
        end
        else if (bvalid_q && s_axi_bready_i)
        begin
          bvalid_q <= 1'b0;
          b_done_q <= 1'b1;
        end
      end
    end
  end

  // address, data and strobe are only sampled while their channel is open
  always_ff @(posedge s_axi_aclk)
  begin
    if (awready_q && s_axi_awvalid_i)
    begin
      awaddr_q <= s_axi_awaddr_i[ADDR_WIDTH-1:2];
    end
    if (wready_q && s_axi_wvalid_i)
    begin
      wdata_q <= s_axi_wdata_i;
      wstrb_q <= s_axi_wstrb_i;
    end
  end

  assign s_axi_awready_o = awready_q;
  assign s_axi_wready_o  = wready_q;
  assign s_axi_bvalid_o  = bvalid_q;
  assign s_axi_bresp_o   = RESP_OKAY;
  assign wr_en_o         = wr_en_q;
  assign wr_req_o        = '{addr: awaddr_q, data: wdata_q, strb: wstrb_q};

  // once offered, a write response stays up until the master takes it
  bvalid_hold_a: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);

  // the register file sees exactly one update per transaction
  wr_en_pulse_a: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    wr_en_o |=> !wr_en_o);

endmodule

`default_nettype wire

// ==== rtl/cfg_axi_read_slave.sv ====
`default_nettype none

module cfg_axi_read_slave (
  input  wire                                      s_axi_aclk,
  input  wire                                      s_axi_aresetn,
  input  wire  [axi_node_cfg_pkg::ADDR_WIDTH-1:0]  s_axi_araddr_i,
  input  wire                                      s_axi_arvalid_i,
  output logic                                     s_axi_arready_o,
  input  wire                                      s_axi_rready_i,
  output logic                                     s_axi_rvalid_o,
  output logic [1:0]                               s_axi_rresp_o,
  output axi_node_cfg_pkg::cfg_word_t              s_axi_rdata_o,
  output axi_node_cfg_pkg::word_addr_t             rd_addr_o,
  input  wire  axi_node_cfg_pkg::cfg_word_t        rd_data_i
);

  import axi_node_cfg_pkg::*;

  logic       arready_q;
  logic       ar_held_q;
  logic       rvalid_q;
  // set on the rready handshake so arready reopens one edge later
  logic       r_done_q;
  logic       launch;
  word_addr_t araddr_q;
  // the decoded word is frozen when rvalid rises, so a write to the same
  // register cannot disturb a response that is already on the bus
  cfg_word_t  rdata_q;

  assign launch = ar_held_q && !rvalid_q && !r_done_q;

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
    begin
      arready_q <= 1'b1;
      ar_held_q <= 1'b0;
      rvalid_q  <= 1'b0;
      r_done_q  <= 1'b0;
    end
    else if (r_done_q)
    begin
      arready_q <= 1'b1;
      ar_held_q <= 1'b0;
      r_done_q  <= 1'b0;
    end
    else
    begin
      if (arready_q && s_axi_arvalid_i)
      begin
        arready_q <= 1'b0;
        ar_held_q <= 1'b1;
      end
      if (launch)
      begin
        rvalid_q <= 1'b1;
      end
      else if (rvalid_q && s_axi_rready_i)
      begin
        rvalid_q <= 1'b0;
        r_done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge s_axi_aclk)
  begin
    if (arready_q && s_axi_arvalid_i)
    begin
      araddr_q <= s_axi_araddr_i[ADDR_WIDTH-1:2];
    end
    if (launch)
    begin
      rdata_q <= rd_data_i;
    end
  end

  assign s_axi_arready_o = arready_q;
  assign s_axi_rvalid_o  = rvalid_q;
  assign s_axi_rresp_o   = RESP_OKAY;
  assign s_axi_rdata_o   = rdata_q;
  assign rd_addr_o       = araddr_q;

  // read data must not move while the master stalls the response
  rdata_stable_a: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_rvalid_o && !s_axi_rready_i |=> $stable(s_axi_rdata_o));

endmodule

`default_nettype wire

// ==== rtl/cfg_reg_file.sv ====
`default_nettype none

module cfg_reg_file #(
  parameter int unsigned N_REGION_MAX  = 4,
  parameter int unsigned N_MASTER_PORT = 4,
  parameter int unsigned N_SLAVE_PORT  = 4
) (
  input  wire                                       s_axi_aclk,
  input  wire                                       s_axi_aresetn,
  input  wire  axi_node_cfg_pkg::cfg_wr_req_t       wr_req_i,
  input  wire                                       wr_en_i,
  input  wire  axi_node_cfg_pkg::word_addr_t        rd_addr_i,
  output axi_node_cfg_pkg::cfg_word_t               rd_data_o,
  input  wire  [N_REGION_MAX-1:0][N_MASTER_PORT-1:0][axi_node_cfg_pkg::DATA_WIDTH-1:0]
                                                    init_start_addr_i,
  input  wire  [N_REGION_MAX-1:0][N_MASTER_PORT-1:0][axi_node_cfg_pkg::DATA_WIDTH-1:0]
                                                    init_end_addr_i,
  input  wire  [N_REGION_MAX-1:0][N_MASTER_PORT-1:0] init_valid_rule_i,
  input  wire  [N_SLAVE_PORT-1:0][N_MASTER_PORT-1:0] init_connectivity_map_i,
  output logic [N_REGION_MAX-1:0][N_MASTER_PORT-1:0][axi_node_cfg_pkg::DATA_WIDTH-1:0]
                                                    start_addr_o,
  output logic [N_REGION_MAX-1:0][N_MASTER_PORT-1:0][axi_node_cfg_pkg::DATA_WIDTH-1:0]
                                                    end_addr_o,
  output logic [N_REGION_MAX-1:0][N_MASTER_PORT-1:0] valid_rule_o,
  output logic [N_SLAVE_PORT-1:0][N_MASTER_PORT-1:0] connectivity_map_o
);

  import axi_node_cfg_pkg::*;

  localparam int unsigned SLOT_BITS = $clog2(WORDS_PER_REGION);

  // where a word address lands in the map
  typedef struct packed {
    logic                 rule_hit;
    logic                 conn_hit;
    logic [SLOT_BITS-1:0] slot;
    int unsigned          region;
    int unsigned          master;
    int unsigned          slave;
  } cfg_decode_t;

  cfg_decode_t wr_dec;
  cfg_decode_t rd_dec;

  // region blocks are laid out master by master, N_REGION_MAX blocks each,
  // and the connectivity words follow at CONN_BASE_WORD
  function automatic cfg_decode_t decode_addr(word_addr_t addr);
    cfg_decode_t dec;
    word_addr_t  blk;
    dec      = '0;
    blk      = addr >> SLOT_BITS;
    dec.slot = addr[SLOT_BITS-1:0];
    for (int m = 0; m < N_MASTER_PORT; m++)
    begin
      for (int r = 0; r < N_REGION_MAX; r++)
      begin
        if (blk == word_addr_t'(m * N_REGION_MAX + r))
        begin
          dec.rule_hit = 1'b1;
          dec.region   = r;
          dec.master   = m;
        end
      end
    end
    for (int s = 0; s < N_SLAVE_PORT; s++)
    begin
      if (addr == word_addr_t'(CONN_BASE_WORD + s))
      begin
        dec.conn_hit = 1'b1;
        dec.slave    = s;
      end
    end
    return dec;
  endfunction

  // byte lanes with a clear strobe keep the old contents
  function automatic cfg_word_t merge_bytes(cfg_word_t old_w, cfg_word_t new_w,
                                            logic [STRB_WIDTH-1:0] strb);
    cfg_word_t res;
    res = old_w;
    for (int b = 0; b < STRB_WIDTH; b++)
    begin
      if (strb[b])
      begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign wr_dec = decode_addr(wr_req_i.addr);
  assign rd_dec = decode_addr(rd_addr_i);

  // storage lives directly in the output registers, sized to what each
  // entry really keeps, so masking falls out of the truncation on write
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
    begin
      start_addr_o       <= init_start_addr_i;
      end_addr_o         <= init_end_addr_i;
      valid_rule_o       <= init_valid_rule_i;
      connectivity_map_o <= init_connectivity_map_i;
    end
    else if (wr_en_i && wr_dec.rule_hit)
    begin
      // the reserved slot falls through and is left untouched
      case (int'(wr_dec.slot))
        RULE_START_SLOT: start_addr_o[wr_dec.region][wr_dec.master] <=
          merge_bytes(start_addr_o[wr_dec.region][wr_dec.master], wr_req_i.data,
                      wr_req_i.strb);
        RULE_END_SLOT: end_addr_o[wr_dec.region][wr_dec.master] <=
          merge_bytes(end_addr_o[wr_dec.region][wr_dec.master], wr_req_i.data,
                      wr_req_i.strb);
        RULE_VALID_SLOT: valid_rule_o[wr_dec.region][wr_dec.master] <=
          wr_req_i.strb[0] ? wr_req_i.data[0] : valid_rule_o[wr_dec.region][wr_dec.master];
        default: ;
      endcase
    end
    else if (wr_en_i && wr_dec.conn_hit)
    begin
      connectivity_map_o[wr_dec.slave] <= N_MASTER_PORT'(
        merge_bytes(cfg_word_t'(connectivity_map_o[wr_dec.slave]), wr_req_i.data,
                    wr_req_i.strb));
    end
  end

  // read mux, unmapped words return zero
  always_comb
  begin
    rd_data_o = '0;
    if (rd_dec.rule_hit)
    begin
      case (int'(rd_dec.slot))
        RULE_START_SLOT: rd_data_o = start_addr_o[rd_dec.region][rd_dec.master];
        RULE_END_SLOT:   rd_data_o = end_addr_o[rd_dec.region][rd_dec.master];
        RULE_VALID_SLOT: rd_data_o = cfg_word_t'(valid_rule_o[rd_dec.region][rd_dec.master]);
        RULE_RSVD_SLOT:  rd_data_o = RSVD_MARKER;
        default:         rd_data_o = '0;
      endcase
    end
    else if (rd_dec.conn_hit)
    begin
      rd_data_o = cfg_word_t'(connectivity_map_o[rd_dec.slave]);
    end
  end

  // a connectivity word needs spare upper bits, and the rule blocks of all
  // masters must fit below the connectivity area
  map_fits_a: assert property (@(posedge s_axi_aclk)
    N_MASTER_PORT < 32 &&
    N_MASTER_PORT * N_REGION_MAX * WORDS_PER_REGION <= CONN_BASE_WORD);

endmodule

`default_nettype wire

// ==== rtl/axi_node_cfg_top.sv ====
`default_nettype none

module axi_node_cfg_top #(
  parameter int unsigned N_REGION_MAX  = 4,
  parameter int unsigned N_MASTER_PORT = 4,
  parameter int unsigned N_SLAVE_PORT  = 4
) (
  input  wire                                       s_axi_aclk,
  input  wire                                       s_axi_aresetn,
  // write address channel
  input  wire  [axi_node_cfg_pkg::ADDR_WIDTH-1:0]   s_axi_awaddr_i,
  input  wire                                       s_axi_awvalid_i,
  output logic                                      s_axi_awready_o,
  // read address channel
  input  wire  [axi_node_cfg_pkg::ADDR_WIDTH-1:0]   s_axi_araddr_i,
  input  wire                                       s_axi_arvalid_i,
  output logic                                      s_axi_arready_o,
  // write data channel
  input  wire  [axi_node_cfg_pkg::DATA_WIDTH-1:0]   s_axi_wdata_i,
  input  wire  [axi_node_cfg_pkg::STRB_WIDTH-1:0]   s_axi_wstrb_i,
  input  wire                                       s_axi_wvalid_i,
  output logic                                      s_axi_wready_o,
  // write response channel
  input  wire                                       s_axi_bready_i,
  output logic [1:0]                                s_axi_bresp_o,
  output logic                                      s_axi_bvalid_o,
  // read data channel
  output logic [axi_node_cfg_pkg::DATA_WIDTH-1:0]   s_axi_rdata_o,
  output logic                                      s_axi_rvalid_o,
  input  wire                                       s_axi_rready_i,
  output logic [1:0]                                s_axi_rresp_o,
  // values loaded while reset is held
  input  wire  [N_REGION_MAX-1:0][N_MASTER_PORT-1:0][axi_node_cfg_pkg::DATA_WIDTH-1:0]
                                                    init_start_addr_i,
  input  wire  [N_REGION_MAX-1:0][N_MASTER_PORT-1:0][axi_node_cfg_pkg::DATA_WIDTH-1:0]
                                                    init_end_addr_i,
  input  wire  [N_REGION_MAX-1:0][N_MASTER_PORT-1:0] init_valid_rule_i,
  input  wire  [N_SLAVE_PORT-1:0][N_MASTER_PORT-1:0] init_connectivity_map_i,
  // current configuration seen by the node
  output logic [N_REGION_MAX-1:0][N_MASTER_PORT-1:0][axi_node_cfg_pkg::DATA_WIDTH-1:0]
                                                    start_addr_o,
  output logic [N_REGION_MAX-1:0][N_MASTER_PORT-1:0][axi_node_cfg_pkg::DATA_WIDTH-1:0]
                                                    end_addr_o,
  output logic [N_REGION_MAX-1:0][N_MASTER_PORT-1:0] valid_rule_o,
  output logic [N_SLAVE_PORT-1:0][N_MASTER_PORT-1:0] connectivity_map_o
);

  import axi_node_cfg_pkg::*;

  // one complete write per pulse of wr_en
  cfg_wr_req_t wr_req;
  logic        wr_en;
  // read address stays put for the whole read transaction
  word_addr_t  rd_addr;
  cfg_word_t   rd_data;

  cfg_axi_write_slave wr_slave_i (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .wr_req_o        (wr_req),
    .wr_en_o         (wr_en)
  );

  cfg_axi_read_slave rd_slave_i (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .rd_addr_o       (rd_addr),
    .rd_data_i       (rd_data)
  );

  cfg_reg_file #(
    .N_REGION_MAX  (N_REGION_MAX),
    .N_MASTER_PORT (N_MASTER_PORT),
    .N_SLAVE_PORT  (N_SLAVE_PORT)
  ) reg_file_i (
    .s_axi_aclk              (s_axi_aclk),
    .s_axi_aresetn           (s_axi_aresetn),
    .wr_req_i                (wr_req),
    .wr_en_i                 (wr_en),
    .rd_addr_i               (rd_addr),
    .rd_data_o               (rd_data),
    .init_start_addr_i       (init_start_addr_i),
    .init_end_addr_i         (init_end_addr_i),
    .init_valid_rule_i       (init_valid_rule_i),
    .init_connectivity_map_i (init_connectivity_map_i),
    .start_addr_o            (start_addr_o),
    .end_addr_o              (end_addr_o),
    .valid_rule_o            (valid_rule_o),
    .connectivity_map_o      (connectivity_map_o)
  );

endmodule

`default_nettype wire

// ==== include/tb_axi_lite_tasks.svh ====
`ifndef TB_AXI_LITE_TASKS_SVH
`define TB_AXI_LITE_TASKS_SVH

// compares one word against its expected value and stops on the first difference
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual)
  begin
    error_count++;
    $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    $display("Test FAILED");
    $fatal(1, "stopping at the first error");
  end
endtask

// one AXI-Lite write with address and data together or data first
task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input bit data_first);
  bit aw_done;
  bit w_done;
  bit aw_acc;
  bit w_acc;
  int stall;
  aw_done       = 1'b0;
  w_done        = 1'b0;
  s_axi_awaddr  = addr;
  s_axi_awvalid = !data_first;
  s_axi_wdata   = data;
  s_axi_wstrb   = strb;
  s_axi_wvalid  = 1'b1;
  while (!(aw_done && w_done))
  begin
    // ready only moves on a rising edge, so it is stable here
    aw_acc = s_axi_awvalid && s_axi_awready;
    w_acc  = s_axi_wvalid && s_axi_wready;
    @(posedge s_axi_aclk);
    @(negedge s_axi_aclk);
    if (aw_acc)
    begin
      s_axi_awvalid = 1'b0;
      aw_done       = 1'b1;
    end
    if (w_acc)
    begin
      s_axi_wvalid = 1'b0;
      w_done       = 1'b1;
    end
    // in data-first mode the address only shows up once the data was taken
    if (w_done && !aw_done)
      s_axi_awvalid = 1'b1;
  end
  while (!s_axi_bvalid)
    @(negedge s_axi_aclk);
  // OKAY is the all-zero response code
  check_value("write response code", 32'h0, 32'(s_axi_bresp));
  stall = $random(seed) & 3;
  repeat (stall)
  begin
    @(posedge s_axi_aclk);
    @(negedge s_axi_aclk);
    check_value("bvalid held under back-pressure", 32'd1, 32'(s_axi_bvalid));
  end
  s_axi_bready = 1'b1;
  @(posedge s_axi_aclk);
  @(negedge s_axi_aclk);
  s_axi_bready = 1'b0;
endtask

// one AXI-Lite read with a random rready stall while rdata is watched
task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
  bit          ar_acc;
  int          stall;
  logic [31:0] first;
  s_axi_araddr  = addr;
  s_axi_arvalid = 1'b1;
  ar_acc        = 1'b0;
  while (!ar_acc)
  begin
    ar_acc = s_axi_arready;
    @(posedge s_axi_aclk);
    @(negedge s_axi_aclk);
  end
  s_axi_arvalid = 1'b0;
  while (!s_axi_rvalid)
    @(negedge s_axi_aclk);
  check_value("read response code", 32'h0, 32'(s_axi_rresp));
  first = s_axi_rdata;
  stall = $random(seed) & 3;
  repeat (stall)
  begin
    @(posedge s_axi_aclk);
    @(negedge s_axi_aclk);
    check_value("rvalid held under back-pressure", 32'd1, 32'(s_axi_rvalid));
    check_value("rdata stable under back-pressure", first, s_axi_rdata);
  end
  s_axi_rready = 1'b1;
  @(posedge s_axi_aclk);
  @(negedge s_axi_aclk);
  s_axi_rready = 1'b0;
  data = first;
endtask

`endif

// ==== tb/tb_axi_node_cfg.sv ====
`default_nettype none

module tb_axi_node_cfg;

  import axi_node_cfg_pkg::*;

  // same sizes as the defaults of the DUT
  localparam int N_R = 4;
  localparam int N_M = 4;
  localparam int N_S = 4;

  localparam logic [1:0] OP_WR    = 2'd0;
  localparam logic [1:0] OP_WR_DF = 2'd1;
  localparam logic [1:0] OP_RD    = 2'd2;

  localparam int KIND_NONE = 0;
  localparam int KIND_RULE = 1;
  localparam int KIND_CONN = 2;

  localparam int N_ROWS      = 32;
  localparam int SWEEP_WORDS = N_M * N_R * 4 + N_S;
  // one transaction with its worst stall stays far below 40 cycles
  localparam int CYCLE_LIMIT = (N_ROWS + SWEEP_WORDS) * 40 + 100;

  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp;
  } stim_row_t;

  // byte address 0x40 steps one master, 0x10 one region, 0x1000 is the connectivity area
  localparam stim_row_t STIM [0:N_ROWS-1] = '{
    // full-word writes to start, end and valid words
    '{OP_WR,    32'h0000_0000, 32'h1000_0000, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_0000, 32'h0000_0000, 4'h0, 32'h1000_0000},
    '{OP_WR,    32'h0000_0004, 32'h1FFF_FFFF, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_0004, 32'h0000_0000, 4'h0, 32'h1FFF_FFFF},
    '{OP_WR,    32'h0000_0008, 32'hFFFF_FFFF, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_0008, 32'h0000_0000, 4'h0, 32'h0000_0001},
    '{OP_WR,    32'h0000_00F8, 32'hFFFF_FFFE, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_00F8, 32'h0000_0000, 4'h0, 32'h0000_0000},
    '{OP_WR,    32'h0000_0064, 32'hCAFE_0123, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_0064, 32'h0000_0000, 4'h0, 32'hCAFE_0123},
    // partial strobes keep the disabled bytes
    '{OP_WR,    32'h0000_0000, 32'hAABB_CCDD, 4'h5, 32'h0000_0000},
    '{OP_RD,    32'h0000_0000, 32'h0000_0000, 4'h0, 32'h10BB_00DD},
    '{OP_WR,    32'h0000_0004, 32'h5566_7788, 4'h8, 32'h0000_0000},
    '{OP_RD,    32'h0000_0004, 32'h0000_0000, 4'h0, 32'h55FF_FFFF},
    '{OP_WR,    32'h0000_0008, 32'h0000_0000, 4'hE, 32'h0000_0000},
    '{OP_RD,    32'h0000_0008, 32'h0000_0000, 4'h0, 32'h0000_0001},
    // connectivity words keep only one bit per master
    '{OP_WR,    32'h0000_1000, 32'hFFFF_FFFF, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_1000, 32'h0000_0000, 4'h0, 32'h0000_000F},
    '{OP_WR,    32'h0000_100C, 32'h0000_00F5, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_100C, 32'h0000_0000, 4'h0, 32'h0000_0005},
    // reserved slot and unmapped words
    '{OP_RD,    32'h0000_000C, 32'h0000_0000, 4'h0, RSVD_MARKER},
    '{OP_WR,    32'h0000_000C, 32'h1234_5678, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_000C, 32'h0000_0000, 4'h0, RSVD_MARKER},
    '{OP_WR,    32'h0000_0100, 32'hFFFF_FFFF, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_0100, 32'h0000_0000, 4'h0, 32'h0000_0000},
    '{OP_WR,    32'h0000_1010, 32'hFFFF_FFFF, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_1010, 32'h0000_0000, 4'h0, 32'h0000_0000},
    '{OP_RD,    32'h0000_0800, 32'h0000_0000, 4'h0, 32'h0000_0000},
    // write data offered before the address
    '{OP_WR_DF, 32'h0000_00B0, 32'h8000_1000, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_00B0, 32'h0000_0000, 4'h0, 32'h8000_1000},
    '{OP_WR_DF, 32'h0000_1004, 32'h0000_000A, 4'hF, 32'h0000_0000},
    '{OP_RD,    32'h0000_1004, 32'h0000_0000, 4'h0, 32'h0000_000A}
  };

  logic s_axi_aclk;
  logic s_axi_aresetn;
  logic [31:0] s_axi_awaddr;
  logic s_axi_awvalid;
  logic s_axi_awready;
  logic [31:0] s_axi_araddr;
  logic s_axi_arvalid;
  logic s_axi_arready;
  logic [31:0] s_axi_wdata;
  logic [3:0] s_axi_wstrb;
  logic s_axi_wvalid;
  logic s_axi_wready;
  logic s_axi_bready;
  logic [1:0] s_axi_bresp;
  logic s_axi_bvalid;
  logic [31:0] s_axi_rdata;
  logic s_axi_rvalid;
  logic s_axi_rready;
  logic [1:0] s_axi_rresp;

  logic [N_R-1:0][N_M-1:0][31:0] init_start_addr;
  logic [N_R-1:0][N_M-1:0][31:0] init_end_addr;
  logic [N_R-1:0][N_M-1:0] init_valid_rule;
  logic [N_S-1:0][N_M-1:0] init_connectivity_map;
  logic [N_R-1:0][N_M-1:0][31:0] start_addr;
  logic [N_R-1:0][N_M-1:0][31:0] end_addr;
  logic [N_R-1:0][N_M-1:0] valid_rule;
  logic [N_S-1:0][N_M-1:0] connectivity_map;

  // reference copy of the register map
  logic [31:0] model_start [N_R][N_M];
  logic [31:0] model_end [N_R][N_M];
  logic model_valid [N_R][N_M];
  logic [N_M-1:0] model_conn [N_S];

  integer seed;
  int error_count;
  int cycle_count;
  stim_row_t row;
  logic [31:0] rd_word;
  logic [31:0] rnd;
  string name;

  `include "tb_axi_lite_tasks.svh"

  axi_node_cfg_top dut_i (
    .s_axi_aclk              (s_axi_aclk),
    .s_axi_aresetn           (s_axi_aresetn),
    .s_axi_awaddr_i          (s_axi_awaddr),
    .s_axi_awvalid_i         (s_axi_awvalid),
    .s_axi_awready_o         (s_axi_awready),
    .s_axi_araddr_i          (s_axi_araddr),
    .s_axi_arvalid_i         (s_axi_arvalid),
    .s_axi_arready_o         (s_axi_arready),
    .s_axi_wdata_i           (s_axi_wdata),
    .s_axi_wstrb_i           (s_axi_wstrb),
    .s_axi_wvalid_i          (s_axi_wvalid),
    .s_axi_wready_o          (s_axi_wready),
    .s_axi_bready_i          (s_axi_bready),
    .s_axi_bresp_o           (s_axi_bresp),
    .s_axi_bvalid_o          (s_axi_bvalid),
    .s_axi_rdata_o           (s_axi_rdata),
    .s_axi_rvalid_o          (s_axi_rvalid),
    .s_axi_rready_i          (s_axi_rready),
    .s_axi_rresp_o           (s_axi_rresp),
    .init_start_addr_i       (init_start_addr),
    .init_end_addr_i         (init_end_addr),
    .init_valid_rule_i       (init_valid_rule),
    .init_connectivity_map_i (init_connectivity_map),
    .start_addr_o            (start_addr),
    .end_addr_o              (end_addr),
    .valid_rule_o            (valid_rule),
    .connectivity_map_o      (connectivity_map)
  );

  // word = master * N_R * 4 + region * 4 + slot, connectivity from CONN_BASE_WORD on
  function automatic void decode_byte_addr(input logic [31:0] addr, output int kind,
                                           output int region, output int master,
                                           output int idx);
    int w;
    w      = int'(addr >> 2);
    kind   = KIND_NONE;
    region = 0;
    master = 0;
    idx    = 0;
    if (w < N_M * N_R * 4)
    begin
      kind   = KIND_RULE;
      idx    = w % 4;
      region = (w / 4) % N_R;
      master = (w / 4) / N_R;
    end
    else if (w >= int'(CONN_BASE_WORD) && w < int'(CONN_BASE_WORD) + N_S)
    begin
      kind = KIND_CONN;
      idx  = w - int'(CONN_BASE_WORD);
    end
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++)
      if (strb[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    int kind;
    int r;
    int m;
    int idx;
    decode_byte_addr(addr, kind, r, m, idx);
    if (kind == KIND_CONN)
      return 32'(model_conn[idx]);
    if (kind != KIND_RULE)
      return 32'h0;
    case (idx)
      0: return model_start[r][m];
      1: return model_end[r][m];
      2: return 32'(model_valid[r][m]);
      default: return RSVD_MARKER;
    endcase
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int kind;
    int r;
    int m;
    int idx;
    logic [31:0] merged;
    decode_byte_addr(addr, kind, r, m, idx);
    merged = merge_lanes(model_read(addr), data, strb);
    if (kind == KIND_RULE && idx == 0)
      model_start[r][m] = merged;
    else if (kind == KIND_RULE && idx == 1)
      model_end[r][m] = merged;
    else if (kind == KIND_RULE && idx == 2)
      model_valid[r][m] = merged[0];
    else if (kind == KIND_CONN)
      model_conn[idx] = merged[N_M-1:0];
  endtask

  // every rule and connectivity output against the reference copy
  task automatic compare_outputs(input string tag);
    for (int r = 0; r < N_R; r++)
      for (int m = 0; m < N_M; m++)
      begin
        check_value($sformatf("%s start_addr_o[%0d][%0d]", tag, r, m),
                    model_start[r][m], start_addr[r][m]);
        check_value($sformatf("%s end_addr_o[%0d][%0d]", tag, r, m),
                    model_end[r][m], end_addr[r][m]);
        check_value($sformatf("%s valid_rule_o[%0d][%0d]", tag, r, m),
                    32'(model_valid[r][m]), 32'(valid_rule[r][m]));
      end
    for (int s = 0; s < N_S; s++)
      check_value($sformatf("%s connectivity_map_o[%0d]", tag, s),
                  32'(model_conn[s]), 32'(connectivity_map[s]));
  endtask

  initial
  begin
    s_axi_aclk = 1'b0;
    forever #20 s_axi_aclk = ~s_axi_aclk;
  end

  // a stuck handshake ends the run here
  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge s_axi_aclk);
      cycle_count++;
    end
    $display("simulation timed out waiting for a handshake");
    $display("Test FAILED");
    $fatal(1, "cycle limit reached");
  end

  initial
  begin
    error_count   = 0;
    seed          = 32'h21e0_c1ca;
    s_axi_aresetn = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_rready  = 1'b0;
    // random init contents, mirrored into the model with the storage widths
    for (int r = 0; r < N_R; r++)
      for (int m = 0; m < N_M; m++)
      begin
        init_start_addr[r][m] = $random(seed);
        init_end_addr[r][m]   = $random(seed);
        rnd                   = $random(seed);
        init_valid_rule[r][m] = rnd[0];
        model_start[r][m]     = init_start_addr[r][m];
        model_end[r][m]       = init_end_addr[r][m];
        model_valid[r][m]     = rnd[0];
      end
    for (int s = 0; s < N_S; s++)
    begin
      rnd                      = $random(seed);
      init_connectivity_map[s] = rnd[N_M-1:0];
      model_conn[s]            = rnd[N_M-1:0];
    end
    repeat (8) @(posedge s_axi_aclk);
    @(negedge s_axi_aclk);
    s_axi_aresetn = 1'b1;
    @(negedge s_axi_aclk);

    compare_outputs("after reset");
    check_value("valid_rule_o equals init", 32'(init_valid_rule), 32'(valid_rule));
    check_value("connectivity_map_o equals init", 32'(init_connectivity_map),
                32'(connectivity_map));
    // every mapped word must read back its init value
    for (int w = 0; w < N_M * N_R * 4; w++)
    begin
      axi_read(32'(w * 4), rd_word);
      check_value($sformatf("reset sweep word %0d", w), model_read(32'(w * 4)), rd_word);
    end
    for (int s = 0; s < N_S; s++)
    begin
      axi_read(32'(CONN_BASE_WORD * 4 + s * 4), rd_word);
      check_value($sformatf("reset sweep slave %0d", s),
                  model_read(32'(CONN_BASE_WORD * 4 + s * 4)), rd_word);
    end

    for (int i = 0; i < N_ROWS; i++)
    begin
      row  = STIM[i];
      name = $sformatf("row %0d at %h", i, row.addr);
      if (row.op == OP_RD)
      begin
        axi_read(row.addr, rd_word);
        check_value(name, row.exp, rd_word);
        check_value({name, " against model"}, model_read(row.addr), rd_word);
      end
      else
      begin
        axi_write(row.addr, row.data, row.strb, row.op == OP_WR_DF);
        model_write(row.addr, row.data, row.strb);
        compare_outputs(name);
      end
    end

    if (error_count == 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
    begin
      $display("Test FAILED");
      $fatal(1, "checks reported errors");
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
rtl/axi_node_cfg_pkg.sv
rtl/cfg_axi_write_slave.sv
rtl/cfg_axi_read_slave.sv
rtl/cfg_reg_file.sv
rtl/axi_node_cfg_top.sv
tb/tb_axi_node_cfg.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the configuration block testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module tb_axi_node_cfg \
  -o sim_tb

# the log is inspected below, so a failing run must not stop the script here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without errors"
exit 0
